// File: verilog/pkt_buf_pkg.sv
package pkt_buf_pkg;

    // pool geometry
    localparam int num_pages  = 64;
    localparam int page_aw    = 6;
    localparam int page_words = 8;
    localparam int word_aw    = 3;
    localparam int word_w     = 16;
    localparam int page_bits  = page_words * word_w;

    // hamming code over one page
    localparam int code_w     = 8;
    localparam int cw_len     = page_bits + code_w;

    localparam int num_ports  = 16;
    localparam int port_w     = 4;
    localparam int cnt_w      = 9;

    // header word fields
    localparam int hdr_port_lsb = 0;
    localparam int hdr_len_lsb  = 4;
    localparam int hdr_len_w    = 6;

    typedef enum logic [1:0] {
        idle,
        first,
        rest
    } wr_state_e;

    // standby is the idle state of the reader
    typedef enum logic [2:0] {
        standby,
        fetch,
        correct,
        stream,
        recycle
    } rd_state_e;

endpackage

// File: verilog/free_page_if.sv
`timescale 1ns/1ps

interface free_page_if;
    import pkt_buf_pkg::*;

    logic               alloc_req;
    logic [page_aw-1:0] alloc_page;
    logic               empty;
    logic               release_req;
    logic [page_aw-1:0] release_page;

    modport owner (input alloc_req, release_req, release_page,
                   output alloc_page, empty);
    modport user  (output alloc_req, release_req, release_page,
                   input alloc_page, empty);

endinterface

// File: verilog/free_page_list.sv
`timescale 1ns/1ps

module free_page_list (
    input  logic                          clk,
    input  logic                          rst_n,
    free_page_if.owner                    fp,
    output logic [pkt_buf_pkg::page_aw:0] free_count
);
    import pkt_buf_pkg::*;

    logic [page_aw-1:0] ring [num_pages];
    logic [page_aw-1:0] head;
    logic [page_aw-1:0] tail;
    logic               filling;
    logic               push;
    logic               pop;

    // during fill the tail index doubles as the page number
    assign push = filling || fp.release_req;
    assign pop  = fp.alloc_req && !fp.empty;

    assign fp.alloc_page = ring[head];
    assign fp.empty      = filling || (free_count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            ring[tail] <= filling ? tail : fp.release_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            filling    <= 1'b1;
            free_count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (filling && free_count == (page_aw + 1)'(num_pages - 1)) begin
                filling <= 1'b0;
            end
            free_count <= free_count + push - pop;
        end
    end

    a_no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) fp.alloc_req |-> !fp.empty);

endmodule

// File: verilog/page_ecc_encoder.sv
`timescale 1ns/1ps

module page_ecc_encoder (
    input  logic [pkt_buf_pkg::page_bits-1:0] page_data,
    output logic [pkt_buf_pkg::code_w-1:0]    code
);
    import pkt_buf_pkg::*;

    // data bits sit at the codeword positions that are not powers of two
    always_comb begin
        int d;
        code = '0;
        d = 0;
        for (int p = 1; p <= cw_len; p++) begin
            if ((p & (p - 1)) != 0) begin
                for (int k = 0; k < code_w; k++) begin
                    if (p[k]) begin
                        code[k] = code[k] ^ page_data[d];
                    end
                end
                d = d + 1;
            end
        end
    end

endmodule

// File: verilog/page_ecc_decoder.sv
`timescale 1ns/1ps

module page_ecc_decoder (
    input  logic [pkt_buf_pkg::page_bits-1:0] page_data,
    input  logic [pkt_buf_pkg::code_w-1:0]    code,
    output logic [pkt_buf_pkg::page_bits-1:0] fixed_data,
    output logic                              corrected
);
    import pkt_buf_pkg::*;

    logic [code_w-1:0] recalc;
    logic [code_w-1:0] syndrome;

    page_ecc_encoder u_enc (
        .page_data (page_data),
        .code      (recalc)
    );

    assign syndrome = recalc ^ code;

    // syndrome is the position of the flipped bit
    always_comb begin
        int d;
        fixed_data = page_data;
        corrected  = 1'b0;
        d = 0;
        for (int p = 1; p <= cw_len; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (syndrome == code_w'(p)) begin
                    fixed_data[d] = ~page_data[d];
                    corrected     = 1'b1;
                end
                d = d + 1;
            end
        end
    end

endmodule

// File: verilog/page_memory.sv
`timescale 1ns/1ps

module page_memory (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [pkt_buf_pkg::page_aw-1:0]   wr_page,
    input  logic [pkt_buf_pkg::word_aw-1:0]   wr_word,
    input  logic [pkt_buf_pkg::word_w-1:0]    wr_data,
    input  logic                              code_en,
    input  logic [pkt_buf_pkg::code_w-1:0]    code_in,
    input  logic                              link_en,
    input  logic [pkt_buf_pkg::page_aw-1:0]   link_in,
    input  logic [pkt_buf_pkg::page_aw-1:0]   rd_page,
    input  logic [pkt_buf_pkg::word_aw-1:0]   rd_word,
    output logic [pkt_buf_pkg::word_w-1:0]    rd_data,
    output logic [pkt_buf_pkg::code_w-1:0]    rd_code,
    output logic [pkt_buf_pkg::page_aw-1:0]   rd_link
);
    import pkt_buf_pkg::*;

    logic [word_w-1:0]  data_mem [num_pages * page_words];
    logic [code_w-1:0]  code_mem [num_pages];
    logic [page_aw-1:0] link_mem [num_pages];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[{wr_page, wr_word}] <= wr_data;
        end
        if (code_en) begin
            code_mem[wr_page] <= code_in;
        end
        if (link_en) begin
            link_mem[wr_page] <= link_in;
        end
        rd_data <= data_mem[{rd_page, rd_word}];
        rd_code <= code_mem[rd_page];
        rd_link <= link_mem[rd_page];
    end

endmodule

// File: verilog/pkt_write_ctrl.sv
`timescale 1ns/1ps

module pkt_write_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              buf_ready,
    input  logic                              wr_vld,
    input  logic [pkt_buf_pkg::word_w-1:0]    wr_data,
    input  logic                              wr_eop,
    input  logic [pkt_buf_pkg::page_bits-1:0] inj_mask,
    output logic                              inj_used,
    free_page_if.user                         fp,
    output logic                              mem_wr_en,
    output logic [pkt_buf_pkg::page_aw-1:0]   mem_page,
    output logic [pkt_buf_pkg::word_aw-1:0]   mem_word,
    output logic [pkt_buf_pkg::word_w-1:0]    mem_data,
    output logic                              code_en,
    output logic [pkt_buf_pkg::code_w-1:0]    code_out,
    output logic                              link_en,
    output logic [pkt_buf_pkg::page_aw-1:0]   link_out,
    output logic                              wr_done,
    output logic [pkt_buf_pkg::page_aw-1:0]   wr_head_addr,
    output logic                              pkt_stored,
    output logic [pkt_buf_pkg::port_w-1:0]    pkt_port,
    output logic                              wr_overflow
);
    import pkt_buf_pkg::*;

    wr_state_e          state;
    logic [word_aw-1:0] word_idx;
    logic [page_aw-1:0] cur_page;
    logic [page_bits-1:0] page_q;
    logic [page_bits-1:0] page_next;
    logic [word_w-1:0]  inj_slice;
    logic               dropping;
    logic               new_page;
    logic               accept;
    logic               page_close;

    assign new_page   = (word_idx == '0);
    assign accept     = wr_vld && !dropping && buf_ready && !(new_page && fp.empty);
    assign page_close = (word_idx == word_aw'(page_words - 1)) || wr_eop;
    assign inj_slice  = inj_mask[word_idx * word_w +: word_w];

    // buffer as it will look after this word, padded with zeros
    always_comb begin
        page_next = new_page ? '0 : page_q;
        page_next[word_idx * word_w +: word_w] = wr_data;
    end

    page_ecc_encoder u_enc (
        .page_data (page_next),
        .code      (code_out)
    );

    assign fp.alloc_req = accept && new_page;
    assign mem_wr_en    = accept;
    assign mem_page     = new_page ? fp.alloc_page : cur_page;
    assign mem_word     = word_idx;
    // error goes to storage only, the code covers the clean word
    assign mem_data     = wr_data ^ inj_slice;
    assign inj_used     = accept && (inj_slice != '0);
    assign code_en      = accept && page_close;
    assign link_en      = accept && page_close;
    // next page to be allocated, the list head does not move until then
    assign link_out     = fp.alloc_page;
    assign pkt_stored   = wr_done;

    always_ff @(posedge clk) begin
        if (accept) begin
            page_q <= page_next;
            if (new_page) begin
                cur_page <= fp.alloc_page;
            end
            if (state == idle) begin
                wr_head_addr <= fp.alloc_page;
                pkt_port     <= wr_data[hdr_port_lsb +: port_w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle;
            word_idx    <= '0;
            dropping    <= 1'b0;
            wr_done     <= 1'b0;
            wr_overflow <= 1'b0;
        end else begin
            wr_done     <= accept && wr_eop;
            wr_overflow <= wr_vld && !dropping && !accept;
            if (wr_vld && !dropping && !accept) begin
                dropping <= !wr_eop;
                state    <= idle;
                word_idx <= '0;
            end else if (dropping) begin
                if (wr_vld && wr_eop) begin
                    dropping <= 1'b0;
                end
            end else if (accept) begin
                word_idx <= wr_eop ? '0 : word_idx + 1'b1;
                if (wr_eop) begin
                    state <= idle;
                end else if (state == idle) begin
                    state <= first;
                end else if (word_idx == word_aw'(page_words - 1)) begin
                    state <= rest;
                end
            end
        end
    end

endmodule

// File: verilog/pkt_read_ctrl.sv
`timescale 1ns/1ps

module pkt_read_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rd_start,
    input  logic [pkt_buf_pkg::page_aw-1:0]   rd_head_addr,
    output logic [pkt_buf_pkg::page_aw-1:0]   mem_page,
    output logic [pkt_buf_pkg::word_aw-1:0]   mem_word,
    input  logic [pkt_buf_pkg::word_w-1:0]    mem_data,
    input  logic [pkt_buf_pkg::code_w-1:0]    mem_code,
    input  logic [pkt_buf_pkg::page_aw-1:0]   mem_link,
    free_page_if.user                         fp,
    output logic                              rd_vld,
    output logic [pkt_buf_pkg::word_w-1:0]    rd_data,
    output logic                              rd_eop,
    output logic                              rd_busy,
    output logic                              pkt_read,
    output logic [pkt_buf_pkg::port_w-1:0]    pkt_port,
    output logic                              ecc_corrected
);
    import pkt_buf_pkg::*;

    rd_state_e            state;
    logic [page_aw-1:0]   page;
    logic [page_aw-1:0]   link_q;
    logic [code_w-1:0]    code_q;
    logic [page_bits-1:0] page_q;
    logic [page_bits-1:0] fixed;
    logic                 corr;
    logic [word_aw:0]     fetch_cnt;
    logic [word_aw-1:0]   sidx;
    logic [hdr_len_w-1:0] remaining;
    logic                 first_page;

    page_ecc_decoder u_dec (
        .page_data  (page_q),
        .code       (code_q),
        .fixed_data (fixed),
        .corrected  (corr)
    );

    assign mem_page        = page;
    assign mem_word        = fetch_cnt[word_aw-1:0];
    assign fp.release_req  = (state == recycle);
    assign fp.release_page = page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= standby;
            rd_busy       <= 1'b0;
            rd_vld        <= 1'b0;
            rd_eop        <= 1'b0;
            pkt_read      <= 1'b0;
            ecc_corrected <= 1'b0;
        end else begin
            rd_vld        <= 1'b0;
            rd_eop        <= 1'b0;
            pkt_read      <= 1'b0;
            ecc_corrected <= 1'b0;
            case (state)
                standby: if (rd_start) begin
                    page       <= rd_head_addr;
                    first_page <= 1'b1;
                    fetch_cnt  <= '0;
                    rd_busy    <= 1'b1;
                    state      <= fetch;
                end
                fetch: begin
                    // read data arrives one cycle behind its address
                    fetch_cnt <= fetch_cnt + 1'b1;
                    if (fetch_cnt != '0) begin
                        page_q[(fetch_cnt - 1'b1) * word_w +: word_w] <= mem_data;
                    end
                    if (fetch_cnt == (word_aw + 1)'(page_words)) begin
                        code_q <= mem_code;
                        link_q <= mem_link;
                        state  <= correct;
                    end
                end
                correct: begin
                    page_q        <= fixed;
                    ecc_corrected <= corr;
                    sidx          <= '0;
                    if (first_page) begin
                        remaining <= fixed[hdr_len_lsb +: hdr_len_w];
                        pkt_port  <= fixed[hdr_port_lsb +: port_w];
                    end
                    state <= stream;
                end
                stream: begin
                    rd_vld    <= 1'b1;
                    rd_data   <= page_q[sidx * word_w +: word_w];
                    rd_eop    <= (remaining == 1);
                    remaining <= remaining - 1'b1;
                    sidx      <= sidx + 1'b1;
                    if (remaining == 1 || sidx == word_aw'(page_words - 1)) begin
                        state <= recycle;
                    end
                end
                recycle: begin
                    first_page <= 1'b0;
                    fetch_cnt  <= '0;
                    page       <= link_q;
                    if (remaining == '0) begin
                        rd_busy  <= 1'b0;
                        pkt_read <= 1'b1;
                        state    <= standby;
                    end else begin
                        state <= fetch;
                    end
                end
                default: state <= standby;
            endcase
        end
    end

    a_no_vld_in_standby: assert property (
        @(posedge clk) disable iff (!rst_n) (state == standby) |-> !rd_vld);

endmodule

// File: verilog/buffer_status_regs.sv
`timescale 1ns/1ps

module buffer_status_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pkt_stored,
    input  logic [pkt_buf_pkg::port_w-1:0]    store_port,
    input  logic                              pkt_read,
    input  logic [pkt_buf_pkg::port_w-1:0]    read_port,
    input  logic                              ecc_corrected,
    input  logic [pkt_buf_pkg::port_w-1:0]    check_port,
    output logic [pkt_buf_pkg::cnt_w-1:0]     check_amount,
    output logic [7:0]                        corr_count,
    input  logic                              inj_arm,
    input  logic [6:0]                        inj_bit,
    output logic [pkt_buf_pkg::page_bits-1:0] inj_mask,
    input  logic                              inj_used
);
    import pkt_buf_pkg::*;

    logic [cnt_w-1:0] amount [num_ports];

    assign check_amount = amount[check_port];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                amount[p] <= '0;
            end
            corr_count <= '0;
            inj_mask   <= '0;
        end else begin
            // store and read of one port in one cycle cancel out
            for (int p = 0; p < num_ports; p++) begin
                amount[p] <= amount[p]
                             + cnt_w'(pkt_stored && store_port == port_w'(p))
                             - cnt_w'(pkt_read && read_port == port_w'(p));
            end
            if (ecc_corrected && corr_count != 8'hff) begin
                corr_count <= corr_count + 1'b1;
            end
            if (inj_arm) begin
                inj_mask <= page_bits'(1) << inj_bit;
            end else if (inj_used) begin
                inj_mask <= '0;
            end
        end
    end

endmodule

// File: verilog/pkt_buffer_top.sv
`timescale 1ns/1ps

module pkt_buffer_top (
    input  logic                            clk,
    input  logic                            rst_n,
    output logic                            buf_ready,
    input  logic                            wr_vld,
    input  logic [pkt_buf_pkg::word_w-1:0]  wr_data,
    input  logic                            wr_eop,
    output logic                            wr_done,
    output logic [pkt_buf_pkg::page_aw-1:0] wr_head_addr,
    output logic                            wr_overflow,
    input  logic                            rd_start,
    input  logic [pkt_buf_pkg::page_aw-1:0] rd_head_addr,
    output logic                            rd_vld,
    output logic [pkt_buf_pkg::word_w-1:0]  rd_data,
    output logic                            rd_eop,
    output logic                            rd_busy,
    input  logic [pkt_buf_pkg::port_w-1:0]  check_port,
    output logic [pkt_buf_pkg::cnt_w-1:0]   check_amount,
    output logic [pkt_buf_pkg::page_aw:0]   free_space,
    output logic [7:0]                      corr_count,
    input  logic                            inj_arm,
    input  logic [6:0]                      inj_bit
);
    import pkt_buf_pkg::*;

    free_page_if fp ();

    logic                 mem_wr_en;
    logic [page_aw-1:0]   mem_wr_page;
    logic [word_aw-1:0]   mem_wr_word;
    logic [word_w-1:0]    mem_wr_data;
    logic                 code_en;
    logic [code_w-1:0]    code_in;
    logic                 link_en;
    logic [page_aw-1:0]   link_in;
    logic [page_aw-1:0]   mem_rd_page;
    logic [word_aw-1:0]   mem_rd_word;
    logic [word_w-1:0]    mem_rd_data;
    logic [code_w-1:0]    mem_rd_code;
    logic [page_aw-1:0]   mem_rd_link;
    logic [page_bits-1:0] inj_mask;
    logic                 inj_used;
    logic                 pkt_stored;
    logic [port_w-1:0]    store_port;
    logic                 pkt_read;
    logic [port_w-1:0]    read_port;
    logic                 ecc_corrected;

    // empty after an exhausted pool must not drop ready again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_ready <= 1'b0;
        end else if (!fp.empty) begin
            buf_ready <= 1'b1;
        end
    end

    free_page_list u_fpl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fp         (fp.owner),
        .free_count (free_space)
    );

    page_memory u_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_page (mem_wr_page),
        .wr_word (mem_wr_word),
        .wr_data (mem_wr_data),
        .code_en (code_en),
        .code_in (code_in),
        .link_en (link_en),
        .link_in (link_in),
        .rd_page (mem_rd_page),
        .rd_word (mem_rd_word),
        .rd_data (mem_rd_data),
        .rd_code (mem_rd_code),
        .rd_link (mem_rd_link)
    );

    pkt_write_ctrl u_wr (
        .clk          (clk),
        .rst_n        (rst_n),
        .buf_ready    (buf_ready),
        .wr_vld       (wr_vld),
        .wr_data      (wr_data),
        .wr_eop       (wr_eop),
        .inj_mask     (inj_mask),
        .inj_used     (inj_used),
        .fp           (fp.user),
        .mem_wr_en    (mem_wr_en),
        .mem_page     (mem_wr_page),
        .mem_word     (mem_wr_word),
        .mem_data     (mem_wr_data),
        .code_en      (code_en),
        .code_out     (code_in),
        .link_en      (link_en),
        .link_out     (link_in),
        .wr_done      (wr_done),
        .wr_head_addr (wr_head_addr),
        .pkt_stored   (pkt_stored),
        .pkt_port     (store_port),
        .wr_overflow  (wr_overflow)
    );

    pkt_read_ctrl u_rd (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_start      (rd_start),
        .rd_head_addr  (rd_head_addr),
        .mem_page      (mem_rd_page),
        .mem_word      (mem_rd_word),
        .mem_data      (mem_rd_data),
        .mem_code      (mem_rd_code),
        .mem_link      (mem_rd_link),
        .fp            (fp.user),
        .rd_vld        (rd_vld),
        .rd_data       (rd_data),
        .rd_eop        (rd_eop),
        .rd_busy       (rd_busy),
        .pkt_read      (pkt_read),
        .pkt_port      (read_port),
        .ecc_corrected (ecc_corrected)
    );

    buffer_status_regs u_stat (
        .clk           (clk),
        .rst_n         (rst_n),
        .pkt_stored    (pkt_stored),
        .store_port    (store_port),
        .pkt_read      (pkt_read),
        .read_port     (read_port),
        .ecc_corrected (ecc_corrected),
        .check_port    (check_port),
        .check_amount  (check_amount),
        .corr_count    (corr_count),
        .inj_arm       (inj_arm),
        .inj_bit       (inj_bit),
        .inj_mask      (inj_mask),
        .inj_used      (inj_used)
    );

endmodule

// File: tests/pkt_buffer_tb.sv
`timescale 1ns/1ps

module pkt_buffer_tb;
    import pkt_buf_pkg::*;

    logic               clk;
    logic               rst_n;
    logic               buf_ready;
    logic               wr_vld;
    logic [word_w-1:0]  wr_data;
    logic               wr_eop;
    logic               wr_done;
    logic [page_aw-1:0] wr_head_addr;
    logic               wr_overflow;
    logic               rd_start;
    logic [page_aw-1:0] rd_head_addr;
    logic               rd_vld;
    logic [word_w-1:0]  rd_data;
    logic               rd_eop;
    logic               rd_busy;
    logic [port_w-1:0]  check_port;
    logic [cnt_w-1:0]   check_amount;
    logic [page_aw:0]   free_space;
    logic [7:0]         corr_count;
    logic               inj_arm;
    logic [6:0]         inj_bit;

    // four entries per packet in the order port, word count, data base and injection bit
    logic [15:0]        pat [64];
    logic [page_aw-1:0] heads [16];
    int                 port_left [num_ports];
    int                 num_pkts;
    int                 num_injected = 0;
    int                 errors = 0;
    int                 tests_failed = 0;
    int                 overflows = 0;
    bit                 timed_out = 1'b0;
    int unsigned        seed_val;

    pkt_buffer_top dut_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && wr_overflow) begin
            overflows <= overflows + 1;
        end
    end

    task automatic check_word(input string name, input logic [word_w-1:0] got,
                              input logic [word_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [page_aw-1:0] got,
                              input logic [page_aw-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_w-1:0] got,
                               input logic [cnt_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    // header word first and then base plus the word index
    function automatic logic [word_w-1:0] pkt_word(input int n, input int i);
        logic [word_w-1:0] w;
        w = pat[4*n+2] + word_w'(i);
        if (i == 0) begin
            w = '0;
            w[hdr_port_lsb +: port_w]   = pat[4*n][port_w-1:0];
            w[hdr_len_lsb +: hdr_len_w] = pat[4*n+1][hdr_len_w-1:0];
        end
        return w;
    endfunction

    function automatic int page_count(input int n);
        return (int'(pat[4*n+1]) + page_words - 1) / page_words;
    endfunction

    task automatic load_patterns();
        for (int i = 0; i < 64; i++) begin
            pat[i] = '0;
        end
        for (int p = 0; p < num_ports; p++) begin
            port_left[p] = 0;
        end
        $readmemh("tests/pkt_buffer_patterns.hex", pat);
        num_pkts = 0;
        while (num_pkts < 16 && pat[4*num_pkts+1] != 16'h0) begin
            num_pkts++;
        end
        if (num_pkts == 0) begin
            $display("the pattern file holds no packets");
            errors++;
        end
    endtask

    task automatic write_packet(input int n);
        int cnt;
        int gap;
        int t;
        cnt = int'(pat[4*n+1]);
        if (pat[4*n+3] != 16'h7f) begin
            @(posedge clk);
            inj_arm <= 1'b1;
            inj_bit <= pat[4*n+3][6:0];
            @(posedge clk);
            inj_arm <= 1'b0;
            num_injected++;
        end
        for (int i = 0; i < cnt; i++) begin
            gap = int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                wr_vld <= 1'b0;
                wr_eop <= 1'b0;
            end
            @(posedge clk);
            wr_vld  <= 1'b1;
            wr_data <= pkt_word(n, i);
            wr_eop  <= (i == cnt - 1);
        end
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_eop <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (wr_done !== 1'b1 && t < 10);
        if (wr_done !== 1'b1) begin
            report_timeout($sformatf("wr_done of packet %0d", n));
            return;
        end
        // wr_done belongs in the cycle right after the last word
        if (t != 1) begin
            $display("wr_done of packet %0d came %0d cycles after its last word", n, t);
            errors++;
        end
        heads[n] = wr_head_addr;
    endtask

    task automatic read_packet(input int n);
        int cnt;
        int k;
        int t;
        cnt = int'(pat[4*n+1]);
        @(posedge clk);
        rd_start     <= 1'b1;
        rd_head_addr <= heads[n];
        @(posedge clk);
        rd_start <= 1'b0;
        k = 0;
        t = 0;
        while (k < cnt && t < 600) begin
            @(negedge clk);
            t++;
            if (rd_vld === 1'b1) begin
                check_word($sformatf("rd_data[%0d]", k), rd_data, pkt_word(n, k));
                check_flag("rd_eop", rd_eop, k == cnt - 1);
                k++;
            end
        end
        if (k < cnt) begin
            report_timeout($sformatf("word %0d of packet %0d", k, n));
            return;
        end
        t = 0;
        while (rd_busy !== 1'b0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (rd_busy !== 1'b0) begin
            report_timeout($sformatf("rd_busy to fall after packet %0d", n));
        end
    endtask

    task automatic check_amount_of(input int p);
        @(posedge clk);
        check_port <= port_w'(p);
        @(negedge clk);
        check_count($sformatf("check_amount[%0d]", p), check_amount, cnt_w'(port_left[p]));
    endtask

    task automatic test_ready();
        int t;
        t = 0;
        while (buf_ready !== 1'b1 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (buf_ready !== 1'b1) begin
            report_timeout("buf_ready");
            return;
        end
        check_count("free_space", cnt_w'(free_space), cnt_w'(num_pages));
        check_flag("wr_done", wr_done, 1'b0);
        check_flag("rd_vld", rd_vld, 1'b0);
        check_flag("rd_eop", rd_eop, 1'b0);
        check_flag("rd_busy", rd_busy, 1'b0);
    endtask

    task automatic test_write_all();
        int next_page;
        next_page = 0;
        for (int n = 0; n < num_pkts; n++) begin
            write_packet(n);
            if (timed_out) begin
                return;
            end
            // pages leave the list in the order of the reset fill
            check_addr("wr_head_addr", heads[n], page_aw'(next_page));
            next_page += page_count(n);
            check_count("free_space", cnt_w'(free_space), cnt_w'(num_pages - next_page));
            port_left[pat[4*n][port_w-1:0]]++;
        end
        if (overflows != 0) begin
            $display("a write was dropped %0d time(s)", overflows);
            errors++;
        end
    endtask

    task automatic test_read_all();
        int corr_before;
        int injected;
        for (int n = 0; n < num_pkts; n++) begin
            corr_before = int'(corr_count);
            injected = (pat[4*n+3] != 16'h7f) ? 1 : 0;
            read_packet(n);
            if (timed_out) begin
                return;
            end
            port_left[pat[4*n][port_w-1:0]]--;
            check_amount_of(int'(pat[4*n][port_w-1:0]));
            check_count("corr_count", cnt_w'(corr_count), cnt_w'(corr_before + injected));
        end
    endtask

    initial begin
        int e0;
        int tests_run;
        rst_n        = 1'b0;
        wr_vld       = 1'b0;
        wr_data      = '0;
        wr_eop       = 1'b0;
        rd_start     = 1'b0;
        rd_head_addr = '0;
        check_port   = '0;
        inj_arm      = 1'b0;
        inj_bit      = '0;
        tests_run    = 0;
        seed_val = $urandom(32'h0e02a325);
        load_patterns();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int t = 1; t <= 6 && !timed_out; t++) begin
            e0 = errors;
            case (t)
                1: test_ready();
                2: test_write_all();
                3: begin
                    for (int p = 0; p < num_ports; p++) begin
                        check_amount_of(p);
                    end
                end
                4: test_read_all();
                5: check_count("corr_count", cnt_w'(corr_count), cnt_w'(num_injected));
                default: check_count("free_space", cnt_w'(free_space), cnt_w'(num_pages));
            endcase
            tests_run++;
            if (errors == e0) begin
                $display("test %0d passed", t);
            end else begin
                tests_failed++;
                $display("test %0d failed with %0d error(s)", t, errors - e0);
            end
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/pkt_buf_pkg.sv
verilog/free_page_if.sv
verilog/free_page_list.sv
verilog/page_ecc_encoder.sv
verilog/page_ecc_decoder.sv
verilog/page_memory.sv
verilog/pkt_write_ctrl.sv
verilog/pkt_read_ctrl.sv
verilog/buffer_status_regs.sv
verilog/pkt_buffer_top.sv
tests/pkt_buffer_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pkt_buffer_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/pkt_buffer_patterns.hex
// columns: port, word count, data base, injection bit (7f means no injection)
// one packet per line, all values in hex
3 05 a100 7f
7 08 b200 21
0 14 c300 7f
3 01 d400 06
f 3f e500 70
7 09 1600 7f
a 10 2700 4f
3 21 3800 7f
c 02 4900 1f
0 11 5a00 7f
5 18 6b00 7f
7 04 7c00 3a
